/* files.f */
rtl/axil_sram_pkg.sv
rtl/sram_req_if.sv
rtl/axil_req_arbiter.sv
rtl/data_sram.sv
rtl/resp_buf.sv
rtl/axil_sram_top.sv
testbench/axil_sram_chk.sv
testbench/axil_sram_tb.sv

/* Makefile */
# Verilator build and run for the AXI4-Lite SRAM testbench

VERILATOR ?= verilator
TOP       ?= axil_sram_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wall -Wno-fatal

FILELIST  := files.f
SRCS      := $(shell cat $(FILELIST))
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^No errors$$" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/axil_sram_tb.sv */
// At most one write and one read in flight; DEPTH fixed at 256 words of 64 bits
module axil_sram_tb;
  import axil_sram_pkg::*;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ADDR_W  = 32;
  localparam int DATA_W  = axil_data_w;
  localparam int DEPTH   = 256;
  localparam int N_TXN   = 600;
  localparam int TXN_CYC = 40;

  logic              i_aclk;
  logic              i_arst_n;
  logic              i_awvalid;
  logic              o_awready;
  logic [ADDR_W-1:0] i_awaddr;
  logic [2:0]        i_awprot;
  logic              i_wvalid;
  logic              o_wready;
  logic [DATA_W-1:0] i_wdata;
  logic [7:0]        i_wstrb;
  logic              o_bvalid;
  logic              i_bready;
  logic [1:0]        o_bresp;
  logic              i_arvalid;
  logic              o_arready;
  logic [ADDR_W-1:0] i_araddr;
  logic [2:0]        i_arprot;
  logic              o_rvalid;
  logic              i_rready;
  logic [DATA_W-1:0] o_rdata;
  logic [1:0]        o_rresp;

  // Reference memory and per-byte written flags
  logic [DATA_W-1:0] mem_model [DEPTH];
  logic [7:0]        byte_written [DEPTH];
  logic [31:0]       lfsr_state;

  axil_sram_top #(
    .ADDR_WIDTH (ADDR_W),
    .DATA_WIDTH (DATA_W),
    .DEPTH      (DEPTH)
  ) i_axil_sram_top (
    .i_aclk    (i_aclk),
    .i_arst_n  (i_arst_n),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_awaddr  (i_awaddr),
    .i_awprot  (i_awprot),
    .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),
    .i_wdata   (i_wdata),
    .i_wstrb   (i_wstrb),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .o_bresp   (o_bresp),
    .i_arvalid (i_arvalid),
    .o_arready (o_arready),
    .i_araddr  (i_araddr),
    .i_arprot  (i_arprot),
    .o_rvalid  (o_rvalid),
    .i_rready  (i_rready),
    .o_rdata   (o_rdata),
    .o_rresp   (o_rresp)
  );

  initial begin
    i_aclk = 1'b0;
    forever #4 i_aclk = ~i_aclk;
  end

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v[i] = lfsr_state[0];
    end
  endtask

  task automatic pick_addr(output int addr);
    logic [63:0] sel;
    logic [63:0] word;
    take_bits(4, sel);
    take_bits(8, word);
    // About one access in sixteen lands beyond DEPTH and aliases a low word
    addr = (sel[3:0] == 4'h0) ? DEPTH + int'(word[7:0]) : int'(word[7:0]);
  endtask

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR %s got %h exp %h", name, got, exp);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  task automatic write_word(input int word, input logic [63:0] data, input logic [7:0] strb,
                            input logic [15:0] pat);
    logic got;
    int   k;
    @(posedge i_aclk);
    #1;
    i_awvalid = 1'b1;
    i_wvalid  = 1'b1;
    i_awaddr  = ADDR_W'(word) << 3;
    i_wdata   = data;
    i_wstrb   = strb;
    @(negedge i_aclk);
    while (!o_awready) begin
      @(negedge i_aclk);
    end
    compare("wready", o_wready, 1'b1);
    @(posedge i_aclk);
    #1;
    i_awvalid = 1'b0;
    i_wvalid  = 1'b0;
    got = 1'b0;
    k = 0;
    while (!got) begin
      i_bready = pat[k % 16];
      k++;
      @(negedge i_aclk);
      if (o_bvalid && i_bready) begin
        compare("bresp", o_bresp, (word < DEPTH) ? resp_okay : resp_slverr);
        got = 1'b1;
      end
      @(posedge i_aclk);
      #1;
    end
    i_bready = 1'b0;
    // Only this write is in flight, so no second B may follow
    compare("bvalid", o_bvalid, 1'b0);
    // Model follows the response and skips out-of-range writes
    if (word < DEPTH) begin
      for (int b = 0; b < 8; b++) begin
        if (strb[b]) begin
          mem_model[word][8*b +: 8] = data[8*b +: 8];
          byte_written[word][b] = 1'b1;
        end
      end
    end
  endtask

  task automatic read_word(input int word, input logic [15:0] pat);
    logic [63:0] mask;
    logic        got;
    int          k;
    @(posedge i_aclk);
    #1;
    i_arvalid = 1'b1;
    i_araddr  = ADDR_W'(word) << 3;
    @(negedge i_aclk);
    while (!o_arready) begin
      @(negedge i_aclk);
    end
    @(posedge i_aclk);
    #1;
    i_arvalid = 1'b0;
    got = 1'b0;
    k = 0;
    while (!got) begin
      i_rready = pat[k % 16];
      k++;
      @(negedge i_aclk);
      if (o_rvalid && i_rready) begin
        if (word >= DEPTH) begin
          compare("rresp", o_rresp, resp_slverr);
          compare("rdata", o_rdata, 64'h0);
        end else begin
          compare("rresp", o_rresp, resp_okay);
          for (int b = 0; b < 8; b++) begin
            mask[8*b +: 8] = {8{byte_written[word][b]}};
          end
          // Bytes never written hold no known value
          if (mask != '0) begin
            compare("rdata", o_rdata & mask, mem_model[word] & mask);
          end
        end
        got = 1'b1;
      end
      @(posedge i_aclk);
      #1;
    end
    i_rready = 1'b0;
    compare("rvalid", o_rvalid, 1'b0);
  endtask

  initial begin
    repeat ((N_TXN + 4) * TXN_CYC) @(posedge i_aclk);
    $display("Timeout: transactions did not complete in time");
    $display("Errors found");
    $fatal(1);
  end

  initial begin
    logic [63:0] op;
    logic [63:0] data;
    logic [63:0] strb;
    logic [63:0] bpat;
    logic [63:0] rpat;
    int          waddr;
    int          raddr;
    lfsr_state = 32'hb114;
    i_arst_n  = 1'b0;
    i_awvalid = 1'b0;
    i_awaddr  = '0;
    i_awprot  = 3'b000;
    i_wvalid  = 1'b0;
    i_wdata   = '0;
    i_wstrb   = '0;
    i_bready  = 1'b0;
    i_arvalid = 1'b0;
    i_araddr  = '0;
    i_arprot  = 3'b000;
    i_rready  = 1'b0;
    for (int i = 0; i < DEPTH; i++) begin
      byte_written[i] = '0;
      mem_model[i]    = '0;
    end
    repeat (2) @(posedge i_aclk);
    #1;
    i_arst_n = 1'b1;
    repeat (2) @(negedge i_aclk);
    compare("bvalid", o_bvalid, 1'b0);
    compare("rvalid", o_rvalid, 1'b0);
    for (int t = 0; t < N_TXN; t++) begin
      take_bits(2, op);
      pick_addr(waddr);
      take_bits(64, data);
      take_bits(10, strb);
      if (strb[9:8] == 2'b00) begin
        strb[7:0] = 8'hff;
      end
      take_bits(16, bpat);
      pick_addr(raddr);
      take_bits(16, rpat);
      // Ready patterns never stall for a full 16 cycles
      bpat[15] = 1'b1;
      rpat[15] = 1'b1;
      case (op[1:0])
        2'd0: write_word(waddr, data, strb[7:0], bpat[15:0]);
        2'd1: read_word(raddr, rpat[15:0]);
        default: begin
          if (op[0]) begin
            raddr = waddr;
          end
          // A read of the word being written waits for the B response
          if (raddr == waddr) begin
            write_word(waddr, data, strb[7:0], bpat[15:0]);
            read_word(raddr, rpat[15:0]);
          end else begin
            fork
              write_word(waddr, data, strb[7:0], bpat[15:0]);
              read_word(raddr, rpat[15:0]);
            join
          end
        end
      endcase
    end
    $display("No errors");
    $finish;
  end

endmodule

/* testbench/axil_sram_chk.sv */
// Bound into axil_sram_top; response buffer depth is assumed to be two
module axil_sram_chk #(
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 64
) (
  input logic                  i_aclk,
  input logic                  i_arst_n,
  input logic                  i_awvalid,
  input logic                  o_awready,
  input logic [ADDR_WIDTH-1:0] i_awaddr,
  input logic                  i_arvalid,
  input logic                  o_arready,
  input logic [ADDR_WIDTH-1:0] i_araddr,
  input logic                  o_bvalid,
  input logic                  i_bready,
  input logic [1:0]            o_bresp,
  input logic                  o_rvalid,
  input logic                  i_rready,
  input logic [DATA_WIDTH-1:0] o_rdata,
  input logic [1:0]            o_rresp,
  input logic [1:0]            b_count,
  input logic [1:0]            r_count
);

  timeunit 1ns;
  timeprecision 1ps;

  aw_stable: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    i_awvalid && !o_awready |=> i_awvalid && $stable(i_awaddr))
    else $error("AW changed before ready");

  ar_stable: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    i_arvalid && !o_arready |=> i_arvalid && $stable(i_araddr))
    else $error("AR changed before ready");

  b_stable: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    o_bvalid && !i_bready |=> o_bvalid && $stable(o_bresp))
    else $error("B changed before ready");

  r_stable: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata) && $stable(o_rresp))
    else $error("R changed before ready");

  // Response valids stay low while reset is held
  no_resp_in_reset: assert property (@(posedge i_aclk)
    !i_arst_n |-> !o_bvalid && !o_rvalid)
    else $error("Response valid during reset");

  buf_no_overflow: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    b_count <= 2'd2 && r_count <= 2'd2)
    else $error("Response buffer count above two");

endmodule

bind axil_sram_top axil_sram_chk #(
  .ADDR_WIDTH (ADDR_WIDTH),
  .DATA_WIDTH (DATA_WIDTH)
) u_chk (
  .i_aclk    (i_aclk),
  .i_arst_n  (i_arst_n),
  .i_awvalid (i_awvalid),
  .o_awready (o_awready),
  .i_awaddr  (i_awaddr),
  .i_arvalid (i_arvalid),
  .o_arready (o_arready),
  .i_araddr  (i_araddr),
  .o_bvalid  (o_bvalid),
  .i_bready  (i_bready),
  .o_bresp   (o_bresp),
  .o_rvalid  (o_rvalid),
  .i_rready  (i_rready),
  .o_rdata   (o_rdata),
  .o_rresp   (o_rresp),
  .b_count   (u_bbuf.count),
  .r_count   (u_rbuf.count)
);

/* rtl/axil_sram_top.sv */
// DATA_WIDTH must equal axil_data_w; AWPROT and ARPROT are ignored, no bursts or unaligned access
module axil_sram_top
  import axil_sram_pkg::*;
#(
  parameter int ADDR_WIDTH      = 32,
  parameter int DATA_WIDTH      = axil_data_w,
  parameter int DEPTH           = 256,
  localparam int STRB_WIDTH     = DATA_WIDTH / 8
) (
  input  logic                  i_aclk,
  input  logic                  i_arst_n,
  // Write address
  input  logic                  i_awvalid,
  output logic                  o_awready,
  input  logic [ADDR_WIDTH-1:0] i_awaddr,
  input  logic [2:0]            i_awprot,
  // Write data
  input  logic                  i_wvalid,
  output logic                  o_wready,
  input  logic [DATA_WIDTH-1:0] i_wdata,
  input  logic [STRB_WIDTH-1:0] i_wstrb,
  // Write response
  output logic                  o_bvalid,
  input  logic                  i_bready,
  output logic [1:0]            o_bresp,
  // Read address
  input  logic                  i_arvalid,
  output logic                  o_arready,
  input  logic [ADDR_WIDTH-1:0] i_araddr,
  input  logic [2:0]            i_arprot,
  // Read data
  output logic                  o_rvalid,
  input  logic                  i_rready,
  output logic [DATA_WIDTH-1:0] o_rdata,
  output logic [1:0]            o_rresp
);

  sram_req_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) req_if ();

  logic                  b_free;
  logic                  r_free;
  logic                  sram_rvalid;
  logic                  sram_rerr;
  logic [DATA_WIDTH-1:0] sram_rdata;
  b_resp_t               b_push_data;
  b_resp_t               b_pop_data;
  r_resp_t               r_push_data;
  r_resp_t               r_pop_data;

  axil_req_arbiter #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .DEPTH      (DEPTH)
  ) u_arb (
    .i_aclk    (i_aclk),
    .i_arst_n  (i_arst_n),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_awaddr  (i_awaddr),
    .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),
    .i_wdata   (i_wdata),
    .i_wstrb   (i_wstrb),
    .i_arvalid (i_arvalid),
    .o_arready (o_arready),
    .i_araddr  (i_araddr),
    .i_b_free  (b_free),
    .i_r_free  (r_free),
    .o_req     (req_if.src)
  );

  data_sram #(
    .DATA_WIDTH (DATA_WIDTH),
    .DEPTH      (DEPTH)
  ) u_sram (
    .i_aclk   (i_aclk),
    .i_arst_n (i_arst_n),
    .i_req    (req_if.dst),
    .o_rvalid (sram_rvalid),
    .o_rerr   (sram_rerr),
    .o_rdata  (sram_rdata)
  );

  assign b_push_data.resp = req_if.in_range ? resp_okay : resp_slverr;
  assign r_push_data.resp = sram_rerr ? resp_slverr : resp_okay;
  assign r_push_data.data = sram_rdata;

  // B is written on the issue edge, so it needs no reservation
  resp_buf #(.payload_t(b_resp_t)) u_bbuf (
    .i_aclk    (i_aclk),
    .i_arst_n  (i_arst_n),
    .i_push    (req_if.valid & req_if.we),
    .i_data    (b_push_data),
    .i_reserve (1'b0),
    .o_free    (b_free),
    .o_valid   (o_bvalid),
    .i_ready   (i_bready),
    .o_data    (b_pop_data)
  );

  resp_buf #(.payload_t(r_resp_t)) u_rbuf (
    .i_aclk    (i_aclk),
    .i_arst_n  (i_arst_n),
    .i_push    (sram_rvalid),
    .i_data    (r_push_data),
    .i_reserve (req_if.valid & ~req_if.we),
    .o_free    (r_free),
    .o_valid   (o_rvalid),
    .i_ready   (i_rready),
    .o_data    (r_pop_data)
  );

  assign o_bresp = b_pop_data.resp;
  assign o_rresp = r_pop_data.resp;
  assign o_rdata = r_pop_data.data;

endmodule

/* rtl/resp_buf.sv */
// Two entries; the producer must check o_free before pushing or reserving, no overflow guard
module resp_buf #(
  parameter type payload_t = logic [1:0]
) (
  input  logic     i_aclk,
  input  logic     i_arst_n,
  input  logic     i_push,
  input  payload_t i_data,
  input  logic     i_reserve,
  output logic     o_free,
  output logic     o_valid,
  input  logic     i_ready,
  output payload_t o_data
);

  payload_t   mem [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic [1:0] rsv;
  logic [2:0] used;
  logic       pop;
  logic       rsv_done;

  assign pop      = o_valid & i_ready;
  assign o_valid  = count != 2'd0;
  assign o_data   = mem[rd_ptr];
  assign used     = count + rsv;
  assign o_free   = used < 3'd2;
  // A push while reservations are open fills one of them
  assign rsv_done = i_push & (rsv != 2'd0);

  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
      rsv    <= 2'd0;
    end else begin
      if (i_push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      case ({i_push, pop})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;
      endcase
      case ({i_reserve, rsv_done})
        2'b10:   rsv <= rsv + 2'd1;
        2'b01:   rsv <= rsv - 2'd1;
        default: rsv <= rsv;
      endcase
    end
  end

  always_ff @(posedge i_aclk) begin
    if (i_push) begin
      mem[wr_ptr] <= i_data;
    end
  end

endmodule

/* rtl/data_sram.sv */
// DEPTH of 2 or more; contents are undefined until written, out-of-range reads give zero
module data_sram #(
  parameter int DATA_WIDTH = 64,
  parameter int DEPTH      = 256
) (
  input  logic                  i_aclk,
  input  logic                  i_arst_n,
  sram_req_if.dst               i_req,
  output logic                  o_rvalid,
  output logic                  o_rerr,
  output logic [DATA_WIDTH-1:0] o_rdata
);

  localparam int IDX_W  = $clog2(DEPTH);
  localparam int STRB_W = DATA_WIDTH / 8;

  logic [DATA_WIDTH-1:0] mem [DEPTH];
  logic [IDX_W-1:0]      idx;
  logic                  do_write;
  logic                  do_read;

  assign idx      = i_req.word_addr[IDX_W-1:0];
  assign do_write = i_req.valid & i_req.we & i_req.in_range;
  assign do_read  = i_req.valid & ~i_req.we;

  // Byte lanes follow wstrb
  always_ff @(posedge i_aclk) begin
    if (do_write) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (i_req.wstrb[b]) begin
          mem[idx][8*b +: 8] <= i_req.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge i_aclk) begin
    if (do_read) begin
      o_rdata <= i_req.in_range ? mem[idx] : '0;
      o_rerr  <= ~i_req.in_range;
    end
  end

  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_rvalid <= 1'b0;
    end else begin
      o_rvalid <= do_read;
    end
  end

endmodule

/* rtl/axil_req_arbiter.sv */
// Aligned accesses only; low address bits below the word size are ignored, one slot per direction
module axil_req_arbiter #(
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 64,
  parameter int DEPTH      = 256
) (
  input  logic                    i_aclk,
  input  logic                    i_arst_n,
  input  logic                    i_awvalid,
  output logic                    o_awready,
  input  logic [ADDR_WIDTH-1:0]   i_awaddr,
  input  logic                    i_wvalid,
  output logic                    o_wready,
  input  logic [DATA_WIDTH-1:0]   i_wdata,
  input  logic [DATA_WIDTH/8-1:0] i_wstrb,
  input  logic                    i_arvalid,
  output logic                    o_arready,
  input  logic [ADDR_WIDTH-1:0]   i_araddr,
  input  logic                    i_b_free,
  input  logic                    i_r_free,
  sram_req_if.src                 o_req
);

  localparam int OFFS_W = $clog2(DATA_WIDTH / 8);
  localparam logic [ADDR_WIDTH-1:0] DEPTH_W = ADDR_WIDTH'(DEPTH);

  logic                    accept_en;
  logic                    wr_full;
  logic                    rd_full;
  logic                    rd_prio;
  logic [ADDR_WIDTH-1:0]   wr_addr;
  logic [ADDR_WIDTH-1:0]   rd_addr;
  logic                    wr_in_range;
  logic                    rd_in_range;
  logic [DATA_WIDTH-1:0]   wr_data;
  logic [DATA_WIDTH/8-1:0] wr_strb;
  logic [ADDR_WIDTH-1:0]   aw_word;
  logic [ADDR_WIDTH-1:0]   ar_word;
  logic                    wr_elig;
  logic                    rd_elig;
  logic                    issue_wr;
  logic                    issue_rd;
  logic                    wr_take;
  logic                    rd_take;

  assign aw_word = i_awaddr >> OFFS_W;
  assign ar_word = i_araddr >> OFFS_W;

  // A slot may go only if its response buffer has room
  assign wr_elig  = wr_full & i_b_free;
  assign rd_elig  = rd_full & i_r_free;
  assign issue_rd = rd_elig & (rd_prio | ~wr_elig);
  assign issue_wr = wr_elig & ~issue_rd;

  // AW and W are taken together, only when both are offered
  assign o_awready = accept_en & (~wr_full | issue_wr) & i_awvalid & i_wvalid;
  assign o_wready  = o_awready;
  assign o_arready = accept_en & (~rd_full | issue_rd);
  assign wr_take   = o_awready;
  assign rd_take   = o_arready & i_arvalid;

  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      accept_en <= 1'b0;
      wr_full   <= 1'b0;
      rd_full   <= 1'b0;
      rd_prio   <= 1'b1;
    end else begin
      accept_en <= 1'b1;
      if (wr_take) begin
        wr_full <= 1'b1;
      end else if (issue_wr) begin
        wr_full <= 1'b0;
      end
      if (rd_take) begin
        rd_full <= 1'b1;
      end else if (issue_rd) begin
        rd_full <= 1'b0;
      end
      // Hand priority to the other side after each issue
      if (issue_rd) begin
        rd_prio <= 1'b0;
      end else if (issue_wr) begin
        rd_prio <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_aclk) begin
    if (wr_take) begin
      wr_addr     <= aw_word;
      wr_in_range <= aw_word < DEPTH_W;
      wr_data     <= i_wdata;
      wr_strb     <= i_wstrb;
    end
    if (rd_take) begin
      rd_addr     <= ar_word;
      rd_in_range <= ar_word < DEPTH_W;
    end
  end

  assign o_req.valid     = issue_wr | issue_rd;
  assign o_req.we        = issue_wr;
  assign o_req.in_range  = issue_wr ? wr_in_range : rd_in_range;
  assign o_req.word_addr = issue_wr ? wr_addr : rd_addr;
  assign o_req.wdata     = wr_data;
  assign o_req.wstrb     = wr_strb;

endmodule

/* rtl/sram_req_if.sv */
// One memory request per cycle; valid is a single-cycle issue strobe with no ready
interface sram_req_if #(
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 64
);

  logic                    valid;
  logic                    we;
  logic                    in_range;
  // Word address, byte offset already removed
  logic [ADDR_WIDTH-1:0]   word_addr;
  logic [DATA_WIDTH-1:0]   wdata;
  logic [DATA_WIDTH/8-1:0] wstrb;

  modport src (
    output valid, we, in_range, word_addr, wdata, wstrb
  );

  modport dst (
    input valid, we, in_range, word_addr, wdata, wstrb
  );

endinterface

/* rtl/axil_sram_pkg.sv */
// Response codes and payload structs; read data is fixed at axil_data_w bits for all users
package axil_sram_pkg;

  // Width of the read data carried in r_resp_t
  localparam int axil_data_w = 64;

  // AXI response codes
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // Write response payload
  typedef struct packed {
    logic [1:0] resp;
  } b_resp_t;

  // Read response payload
  typedef struct packed {
    logic [1:0]             resp;
    logic [axil_data_w-1:0] data;
  } r_resp_t;

endpackage
